// File: design/im2col_pkg.sv
// ******************************
// Shared types for the im2col sequencer
// Widths, descriptor, config, bus request
// DMA register order and control states
// ******************************
`default_nettype none

package im2col_pkg;

  localparam int unsigned DMA_CH_NUM_DEFAULT = 4;
  localparam int unsigned DESC_DEPTH_DEFAULT = 8;
  localparam int unsigned DMA_CH_MAX         = 32;  // Widest channel mask supported

  typedef logic [31:0]           addr_t;
  typedef logic [31:0]           data_t;
  typedef logic [31:0]           ptr_t;
  typedef logic [7:0]            pad_t;
  typedef logic [15:0]           size_t;
  typedef logic [22:0]           inc_t;
  typedef logic [1:0]            dtype_t;  // 0 word, 1 half-word, 2 byte
  typedef logic [3:0]            log_stride_t;
  typedef logic [15:0]           slot_t;
  typedef logic [DMA_CH_MAX-1:0] ch_mask_t;
  typedef logic [3:0]            reg_sel_t;

  // DMA register write order, header first
  localparam reg_sel_t REG_DIM        = 4'd0;
  localparam reg_sel_t REG_SLOT       = 4'd1;
  localparam reg_sel_t REG_SRC_TYPE   = 4'd2;
  localparam reg_sel_t REG_DST_TYPE   = 4'd3;
  localparam reg_sel_t REG_PAD_TOP    = 4'd4;
  localparam reg_sel_t REG_PAD_BOTTOM = 4'd5;
  localparam reg_sel_t REG_PAD_LEFT   = 4'd6;
  localparam reg_sel_t REG_PAD_RIGHT  = 4'd7;
  localparam reg_sel_t REG_SRC_PTR    = 4'd8;
  localparam reg_sel_t REG_DST_PTR    = 4'd9;
  localparam reg_sel_t REG_INC_SRC_D1 = 4'd10;
  localparam reg_sel_t REG_INC_SRC_D2 = 4'd11;
  localparam reg_sel_t REG_INC_DST_D1 = 4'd12;
  localparam reg_sel_t REG_INC_DST_D2 = 4'd13;
  localparam reg_sel_t REG_SIZE_D2    = 4'd14;
  localparam reg_sel_t REG_SIZE_D1    = 4'd15;

  localparam reg_sel_t REG_FIRST_BODY  = 4'd4;   // Later descriptors start here
  localparam addr_t    REG_OFFSET_STEP = 32'd4;  // Byte distance between registers

  typedef struct packed {
    pad_t  pad_top;
    pad_t  pad_bottom;
    pad_t  pad_left;
    pad_t  pad_right;
    ptr_t  src_ptr;
    ptr_t  dst_ptr;
    inc_t  in_inc_d2;
    size_t size_d1;
    size_t size_d2;
    logic  last;  // Final tile of the job
  } im2col_desc_t;

  typedef struct packed {
    addr_t       ch_offset;
    ch_mask_t    ch_mask;
    slot_t       tx_slot;
    slot_t       rx_slot;
    dtype_t      data_type;
    log_stride_t log_stride_d1;
    logic        irq_en;
  } im2col_cfg_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
    data_t wdata;
  } reg_wr_t;

  typedef enum logic [1:0] {
    IDLE,
    GET,
    LOAD
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: design/im2col_desc_queue.sv
// ******************************
// Fall-through descriptor queue
// One credit returned per pop
// ******************************
`timescale 1ns/10ps
`default_nettype none

module im2col_desc_queue #(
  parameter int unsigned DEPTH = im2col_pkg::DESC_DEPTH_DEFAULT
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     push_i,
  input  im2col_pkg::im2col_desc_t desc_i,
  input  logic                     pop_i,
  output im2col_pkg::im2col_desc_t desc_o,
  output logic                     empty_o,
  output logic                     credit_o
);
  import im2col_pkg::*;

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  im2col_desc_t           mem_q [DEPTH];
  logic [PTR_W-1:0]       wr_ptr_q;
  logic [PTR_W-1:0]       rd_ptr_q;
  logic [CNT_W-1:0]       count_q;
  logic                   credit_q;
  logic                   do_push;
  logic                   do_pop;

  assign empty_o  = (count_q == '0);
  assign do_pop   = pop_i && !empty_o;
  assign do_push  = push_i && ((count_q != CNT_W'(DEPTH)) || do_pop);
  assign desc_o   = mem_q[rd_ptr_q];  // Head is visible while not empty
  assign credit_o = credit_q;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= desc_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      credit_q <= do_pop;
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/im2col_ctrl_fsm.sv
// ******************************
// Job and channel control FSM
// Channel-free tracking, done pulse
// Busy status and interrupt flag
// ******************************
`timescale 1ns/10ps
`default_nettype none

module im2col_ctrl_fsm #(
  parameter int unsigned DMA_CH_NUM = im2col_pkg::DMA_CH_NUM_DEFAULT
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 start_i,
  input  logic                 irq_en_i,
  input  logic                 irq_clear_i,
  input  im2col_pkg::ch_mask_t ch_mask_i,
  input  im2col_pkg::ch_mask_t dma_done_i,
  input  logic                 q_empty_i,
  input  logic                 head_last_i,
  input  logic                 seq_done_i,
  output logic                 seq_start_o,
  output logic                 first_o,
  output logic                 pop_o,
  output logic                 busy_o,
  output logic                 done_o,
  output logic                 irq_o
);
  import im2col_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        ch_free_q;
  logic        first_q;     // Next descriptor gets the header
  logic        finished_q;  // Last descriptor loaded
  logic        busy_q;
  logic        done_q;
  logic        irq_q;
  logic        ch_done;
  logic        dispatch;
  logic        job_end;

  // Completions on unmasked channels are ignored
  assign ch_done  = |(ch_mask_i[DMA_CH_NUM-1:0] & dma_done_i[DMA_CH_NUM-1:0]);
  assign dispatch = busy_q && !finished_q && !q_empty_i && ch_free_q;
  assign job_end  = finished_q && ch_free_q;

  always_comb begin
    state_d     = state_q;
    seq_start_o = 1'b0;
    pop_o       = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (dispatch) begin
          state_d = GET;
        end
      end
      GET: begin
        seq_start_o = 1'b1;  // Channel claimed on this edge
        state_d     = LOAD;
      end
      LOAD: begin
        if (seq_done_i) begin
          pop_o   = 1'b1;
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      ch_free_q  <= 1'b1;
      first_q    <= 1'b1;
      finished_q <= 1'b0;
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= job_end;  // One cycle, finished_q drops with it
      if (ch_done) begin
        ch_free_q <= 1'b1;
      end
      if (state_q == GET) begin
        ch_free_q <= 1'b0;
      end
      if (pop_o) begin
        first_q <= 1'b0;
        if (head_last_i) begin
          finished_q <= 1'b1;
        end
      end
      if (job_end) begin
        finished_q <= 1'b0;
        busy_q     <= 1'b0;
      end
      // A new job restarts the header and frees the channel
      if (start_i) begin
        busy_q     <= 1'b1;
        ch_free_q  <= 1'b1;
        first_q    <= 1'b1;
        finished_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_q <= 1'b0;
    end else if (job_end && irq_en_i) begin
      irq_q <= 1'b1;  // Rises together with done_o
    end else if (irq_clear_i) begin
      irq_q <= 1'b0;
    end
  end

  assign first_o = first_q;
  assign busy_o  = busy_q;
  assign done_o  = done_q;
  assign irq_o   = irq_q;

endmodule

`default_nettype wire

// File: design/im2col_reg_counter.sv
// ******************************
// DMA register write sequencer
// Header skipped after first tile
// ******************************
`timescale 1ns/10ps
`default_nettype none

module im2col_reg_counter (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 start_i,
  input  logic                 first_i,
  input  logic                 accept_i,
  output im2col_pkg::reg_sel_t sel_o,
  output logic                 active_o,
  output logic                 seq_done_o
);
  import im2col_pkg::*;

  reg_sel_t sel_q;
  reg_sel_t start_sel;
  logic     active_q;
  logic     seq_done_q;
  logic     last_accept;

  assign start_sel   = first_i ? REG_DIM : REG_FIRST_BODY;
  assign last_accept = active_q && accept_i && (sel_q == REG_SIZE_D1);

  // Start index is shown in the start cycle so the bus master can load it
  assign sel_o      = start_i ? start_sel : sel_q;
  assign active_o   = start_i || active_q;
  assign seq_done_o = seq_done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q      <= REG_DIM;
      active_q   <= 1'b0;
      seq_done_q <= 1'b0;
    end else begin
      seq_done_q <= last_accept;
      if (start_i) begin
        sel_q    <= start_sel;
        active_q <= 1'b1;
      end else if (last_accept) begin
        active_q <= 1'b0;
      end else if (active_q && accept_i) begin
        sel_q <= sel_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/im2col_reg_word.sv
// ******************************
// DMA register address and data
// built from descriptor and config
// ******************************
`timescale 1ns/10ps
`default_nettype none

module im2col_reg_word (
  input  im2col_pkg::reg_sel_t     sel_i,
  input  im2col_pkg::im2col_desc_t desc_i,
  input  im2col_pkg::im2col_cfg_t  cfg_i,
  output im2col_pkg::addr_t        addr_o,
  output im2col_pkg::data_t        wdata_o
);
  import im2col_pkg::*;

  logic [1:0] du_shift;  // Bytes per data unit, as a shift

  assign du_shift = 2'd2 - cfg_i.data_type;
  assign addr_o   = cfg_i.ch_offset + REG_OFFSET_STEP * addr_t'(sel_i);

  always_comb begin
    wdata_o = '0;
    unique case (sel_i)
      REG_DIM: begin
        wdata_o = 32'd1;  // Two-dimensional transfer
      end
      REG_SLOT: begin
        wdata_o = {cfg_i.tx_slot, cfg_i.rx_slot};
      end
      REG_SRC_TYPE, REG_DST_TYPE: begin
        wdata_o = {30'h0, cfg_i.data_type};
      end
      REG_PAD_TOP:    wdata_o = {24'h0, desc_i.pad_top};
      REG_PAD_BOTTOM: wdata_o = {24'h0, desc_i.pad_bottom};
      REG_PAD_LEFT:   wdata_o = {24'h0, desc_i.pad_left};
      REG_PAD_RIGHT:  wdata_o = {24'h0, desc_i.pad_right};
      REG_SRC_PTR:    wdata_o = desc_i.src_ptr;
      REG_DST_PTR:    wdata_o = desc_i.dst_ptr;
      REG_INC_SRC_D1: begin
        // Stride in bytes, limited to the 6-bit field
        wdata_o = ((32'd1 << cfg_i.log_stride_d1) << du_shift) & 32'h3f;
      end
      REG_INC_SRC_D2: begin
        wdata_o = ({9'h0, desc_i.in_inc_d2} << du_shift) & 32'h7fffff;
      end
      REG_INC_DST_D1, REG_INC_DST_D2: begin
        wdata_o = 32'd4 >> cfg_i.data_type;  // Dense output
      end
      REG_SIZE_D2:    wdata_o = {16'h0, desc_i.size_d2};
      REG_SIZE_D1:    wdata_o = {16'h0, desc_i.size_d1};  // Starts the DMA
      default:        wdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/im2col_bus_master.sv
// ******************************
// Register bus write master
// Holds each request until ready
// ******************************
`timescale 1ns/10ps
`default_nettype none

module im2col_bus_master (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                active_i,
  input  im2col_pkg::addr_t   addr_i,
  input  im2col_pkg::data_t   wdata_i,
  input  logic                bus_ready_i,
  output im2col_pkg::reg_wr_t bus_req_o,
  output logic                accept_o
);
  import im2col_pkg::*;

  logic  valid_q;
  addr_t addr_q;
  data_t wdata_q;
  logic  load;

  // New index pending and the bus is free
  assign load     = active_i && !valid_q;
  assign accept_o = valid_q && bus_ready_i;

  always_ff @(posedge clk_i) begin
    if (load) begin
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (accept_o) begin
      valid_q <= 1'b0;  // One idle cycle before the next write
    end
  end

  assign bus_req_o = '{valid: valid_q, addr: addr_q, wdata: wdata_q};

endmodule

`default_nettype wire

// File: design/im2col_spc.sv
// ******************************
// im2col transfer sequencer top
// Queue, control FSM, counter,
// word builder and bus master
// ******************************
`timescale 1ns/10ps
`default_nettype none

module im2col_spc #(
  parameter int unsigned DMA_CH_NUM = im2col_pkg::DMA_CH_NUM_DEFAULT,
  parameter int unsigned DESC_DEPTH = im2col_pkg::DESC_DEPTH_DEFAULT
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     start_i,
  input  im2col_pkg::im2col_cfg_t  cfg_i,
  input  logic                     irq_clear_i,
  input  logic                     desc_valid_i,
  input  im2col_pkg::im2col_desc_t desc_i,
  input  logic                     bus_ready_i,
  input  im2col_pkg::ch_mask_t     dma_done_i,
  output logic                     credit_o,
  output im2col_pkg::reg_wr_t      bus_req_o,
  output logic                     busy_o,
  output logic                     done_o,
  output logic                     irq_o
);
  import im2col_pkg::*;

  im2col_desc_t head_desc;
  logic         q_empty;
  logic         q_pop;
  logic         seq_start;
  logic         seq_first;
  logic         seq_done;
  reg_sel_t     reg_sel;
  logic         reg_active;
  logic         wr_accept;
  addr_t        wr_addr;
  data_t        wr_wdata;

  im2col_desc_queue #(
    .DEPTH(DESC_DEPTH)
  ) u_queue (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .push_i   (desc_valid_i),
    .desc_i   (desc_i),
    .pop_i    (q_pop),
    .desc_o   (head_desc),
    .empty_o  (q_empty),
    .credit_o (credit_o)
  );

  im2col_ctrl_fsm #(
    .DMA_CH_NUM(DMA_CH_NUM)
  ) u_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (start_i),
    .irq_en_i    (cfg_i.irq_en),
    .irq_clear_i (irq_clear_i),
    .ch_mask_i   (cfg_i.ch_mask),
    .dma_done_i  (dma_done_i),
    .q_empty_i   (q_empty),
    .head_last_i (head_desc.last),
    .seq_done_i  (seq_done),
    .seq_start_o (seq_start),
    .first_o     (seq_first),
    .pop_o       (q_pop),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .irq_o       (irq_o)
  );

  im2col_reg_counter u_counter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (seq_start),
    .first_i    (seq_first),
    .accept_i   (wr_accept),
    .sel_o      (reg_sel),
    .active_o   (reg_active),
    .seq_done_o (seq_done)
  );

  im2col_reg_word u_word (
    .sel_i   (reg_sel),
    .desc_i  (head_desc),
    .cfg_i   (cfg_i),
    .addr_o  (wr_addr),
    .wdata_o (wr_wdata)
  );

  im2col_bus_master u_bus (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .active_i    (reg_active),
    .addr_i      (wr_addr),
    .wdata_i     (wr_wdata),
    .bus_ready_i (bus_ready_i),
    .bus_req_o   (bus_req_o),
    .accept_o    (wr_accept)
  );

endmodule

`default_nettype wire

// File: sim/im2col_chk.sv
// ******************************
// Bound assertions on the top level
// Bus hold, done pulse, credit use
// ******************************
`timescale 1ns/10ps
`default_nettype none

module im2col_chk #(
  parameter int unsigned DESC_DEPTH = im2col_pkg::DESC_DEPTH_DEFAULT
) (
  input logic                               clk_i,
  input logic                               rst_ni,
  input im2col_pkg::reg_wr_t                bus_req_o,
  input logic                               bus_ready_i,
  input logic                               done_o,
  input logic                               push_i,
  input logic                               pop_i,
  input logic [$clog2(DESC_DEPTH+1)-1:0]    fill_i
);
  import im2col_pkg::*;

  localparam int unsigned FILL_W = $clog2(DESC_DEPTH + 1);

  // Stalled request keeps address and data
  req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_o.valid && !bus_ready_i |=> bus_req_o.valid && $stable(bus_req_o.addr)
      && $stable(bus_req_o.wdata))
    else $error("bus request changed while stalled");

  done_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |=> !done_o)
    else $error("done_o longer than one cycle");

  // Producer holds a credit for every push
  push_room: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i && (fill_i == FILL_W'(DESC_DEPTH)) |-> pop_i)
    else $error("descriptor pushed into a full queue");

endmodule

bind im2col_spc im2col_chk #(
  .DESC_DEPTH(DESC_DEPTH)
) u_chk (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .bus_req_o   (bus_req_o),
  .bus_ready_i (bus_ready_i),
  .done_o      (done_o),
  .push_i      (desc_valid_i),
  .pop_i       (q_pop),
  .fill_i      (u_queue.count_q)
);

`default_nettype wire

// File: sim/im2col_monitor.sv
// ******************************
// Checker for the im2col sequencer
// Predicts every DMA register write
// Checks done, busy, irq and credits
// ******************************
`timescale 1ns/10ps
`default_nettype none

module im2col_monitor #(
  parameter int unsigned DMA_CH_NUM = im2col_pkg::DMA_CH_NUM_DEFAULT
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic [127:0]             name_i,
  input  logic                     start_i,
  input  im2col_pkg::im2col_cfg_t  cfg_i,
  input  logic                     desc_valid_i,
  input  im2col_pkg::im2col_desc_t desc_i,
  input  logic                     bus_ready_i,
  input  im2col_pkg::reg_wr_t      bus_req_i,
  input  im2col_pkg::ch_mask_t     dma_done_i,
  input  logic                     credit_i,
  input  logic                     busy_i,
  input  logic                     done_i,
  input  logic                     irq_i,
  input  logic                     irq_clear_i,
  output int                       err_o
);
  import im2col_pkg::*;

  im2col_desc_t exp_q [$];
  im2col_desc_t cur;
  reg_sel_t     sel;
  logic         first;
  logic         in_desc;
  logic         ch_busy;      // Waiting for the masked completion
  logic         last_loaded;
  logic         clr_d;
  logic         start_d;
  logic         busy_d;
  logic         irq_d;
  int           pushes;
  int           credits;

  // Expected register word, written from the register table
  function automatic data_t expect_word(reg_sel_t s, im2col_desc_t d, im2col_cfg_t c);
    data_t unit_bytes;
    case (c.data_type)
      2'd0:    unit_bytes = 32'd4;  // Word
      2'd1:    unit_bytes = 32'd2;  // Half-word
      default: unit_bytes = 32'd1;  // Byte
    endcase
    case (s)
      4'd0:       return 32'd1;
      4'd1:       return {c.tx_slot, c.rx_slot};
      4'd2, 4'd3: return {30'h0, c.data_type};
      4'd4:       return {24'h0, d.pad_top};
      4'd5:       return {24'h0, d.pad_bottom};
      4'd6:       return {24'h0, d.pad_left};
      4'd7:       return {24'h0, d.pad_right};
      4'd8:       return d.src_ptr;
      4'd9:       return d.dst_ptr;
      4'd10:      return ((32'd1 << c.log_stride_d1) * unit_bytes) & 32'h3f;
      4'd11:      return ({9'h0, d.in_inc_d2} * unit_bytes) & 32'h7fffff;
      4'd12, 4'd13: return unit_bytes;
      4'd14:      return {16'h0, d.size_d2};
      default:    return {16'h0, d.size_d1};
    endcase
  endfunction

  task automatic show_mismatch(string what, data_t exp_v, data_t act_v);
    $display("FAILED %0s: %0s expected %08h actual %08h", name_i, what, exp_v, act_v);
    err_o++;
  endtask

  task automatic log_error(string msg);
    $display("ERROR %0s: %0s", name_i, msg);
    err_o++;
  endtask

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      exp_q.delete();
      sel         = '0;
      first       = 1'b1;
      in_desc     = 1'b0;
      ch_busy     = 1'b0;
      last_loaded = 1'b0;
      clr_d       = 1'b0;
      start_d     = 1'b0;
      busy_d      = 1'b0;
      irq_d       = 1'b0;
      pushes      = 0;
      credits     = 0;
      err_o       = 0;
    end else begin
      if (start_d && !busy_i) log_error("busy_o not set after start_i");
      if (busy_d && !busy_i && !done_i) log_error("busy_o fell before done_o");
      if (irq_i && !irq_d && !done_i) log_error("irq_o rose without done_o");
      if (start_i) begin  // New job starts with a header
        first       = 1'b1;
        ch_busy     = 1'b0;
        last_loaded = 1'b0;
        pushes      = 0;
        credits     = 0;
      end
      if (desc_valid_i) begin
        exp_q.push_back(desc_i);
        pushes++;
      end
      if (credit_i) credits++;
      if (bus_req_i.valid && bus_ready_i) begin
        if (ch_busy) log_error("write accepted while the DMA channel was busy");
        if (!in_desc) begin
          if (exp_q.size() == 0) begin
            log_error("write accepted with no descriptor queued");
          end else begin
            cur     = exp_q.pop_front();
            sel     = first ? 4'd0 : 4'd4;
            first   = 1'b0;
            in_desc = 1'b1;
          end
        end
        if (in_desc) begin
          check_write(sel);
          if (sel == 4'd15) begin
            in_desc = 1'b0;
            ch_busy = 1'b1;
            if (cur.last) last_loaded = 1'b1;
          end else begin
            sel = sel + 4'd1;
          end
        end
      end
      if (|(cfg_i.ch_mask[DMA_CH_NUM-1:0] & dma_done_i[DMA_CH_NUM-1:0])) ch_busy = 1'b0;
      if (done_i) begin
        if (!last_loaded || ch_busy || in_desc || exp_q.size() != 0) begin
          log_error("done_o before the job finished");
        end
        if (busy_i) log_error("busy_o still high with done_o");
        if (credits != pushes) show_mismatch("credit count", pushes, credits);
        if (cfg_i.irq_en && !irq_i) log_error("irq_o not set with done_o");
        last_loaded = 1'b0;
      end
      if (!cfg_i.irq_en && irq_i) log_error("irq_o set with interrupts disabled");
      if (clr_d && irq_i && !done_i) log_error("irq_o not cleared");
      clr_d   = irq_clear_i;
      start_d = start_i;
      busy_d  = busy_i;
      irq_d   = irq_i;
    end
  end

  task automatic check_write(reg_sel_t s);
    addr_t exp_a;
    data_t exp_d;
    exp_a = cfg_i.ch_offset + 32'd4 * {28'h0, s};
    exp_d = expect_word(s, cur, cfg_i);
    if (bus_req_i.addr !== exp_a) show_mismatch("write address", exp_a, bus_req_i.addr);
    if (bus_req_i.wdata !== exp_d) show_mismatch("write data", exp_d, bus_req_i.wdata);
  endtask

endmodule

`default_nettype wire

// File: sim/im2col_tb.sv
// ******************************
// Testbench top for im2col_spc
// Clock, reset, job table, producer
// Register bus and DMA channel model
// ******************************
`timescale 1ns/10ps
`default_nettype none

module im2col_tb;
  import im2col_pkg::*;

  localparam int unsigned DMA_CH_NUM = 4;
  localparam int unsigned DESC_DEPTH = 8;
  localparam int          NJOBS      = 5;
  localparam int          MAX_DESC   = 12;
  localparam int          MAX_STALL  = 30;  // Cycles allowed per write

  logic         clk_i;
  logic         rst_ni;
  logic         start_i;
  im2col_cfg_t  cfg_i;
  logic         irq_clear_i;
  logic         desc_valid_i;
  im2col_desc_t desc_i;
  logic         bus_ready_i;
  ch_mask_t     dma_done_i;
  logic         credit_o;
  reg_wr_t      bus_req_o;
  logic         busy_o;
  logic         done_o;
  logic         irq_o;

  logic [127:0] name_tab   [NJOBS];
  im2col_cfg_t  cfg_tab    [NJOBS];
  int           ndesc_tab  [NJOBS];
  int unsigned  stall_tab  [NJOBS];
  ch_mask_t     unmask_tab [NJOBS];
  im2col_desc_t desc_tab   [NJOBS][MAX_DESC];

  logic [127:0] cur_name;
  int unsigned  cur_stall;
  ch_mask_t     cur_unmask;
  int unsigned  dma_wait;
  int           used;        // Credits spent by the producer
  int           returned;    // Credits given back
  int           mon_err;
  int unsigned  cycle_cnt;
  int unsigned  limit;
  int unsigned  seed_val;

  im2col_spc #(
    .DMA_CH_NUM(DMA_CH_NUM),
    .DESC_DEPTH(DESC_DEPTH)
  ) dut (
    .clk_i, .rst_ni, .start_i, .cfg_i, .irq_clear_i, .desc_valid_i, .desc_i,
    .bus_ready_i, .dma_done_i, .credit_o, .bus_req_o, .busy_o, .done_o, .irq_o
  );

  im2col_monitor #(
    .DMA_CH_NUM(DMA_CH_NUM)
  ) u_monitor (
    .clk_i, .rst_ni, .name_i(cur_name), .start_i, .cfg_i, .desc_valid_i, .desc_i,
    .bus_ready_i, .bus_req_i(bus_req_o), .dma_done_i, .credit_i(credit_o),
    .busy_i(busy_o), .done_i(done_o), .irq_i(irq_o), .irq_clear_i, .err_o(mon_err)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic add_job(int j, logic [127:0] name, dtype_t dt, int n, logic irq,
                         int unsigned stall, int mbit, log_stride_t ls);
    logic [31:0] r;
    name_tab[j]   = name;
    ndesc_tab[j]  = n;
    stall_tab[j]  = stall;
    unmask_tab[j] = ch_mask_t'(1) << ((mbit + 1) % DMA_CH_NUM);
    r = $urandom;
    cfg_tab[j] = '{ch_offset: 32'h4000_0000 + 32'h1000 * j, ch_mask: ch_mask_t'(1) << mbit,
                   tx_slot: r[31:16], rx_slot: r[15:0], data_type: dt,
                   log_stride_d1: ls, irq_en: irq};
    for (int k = 0; k < n; k++) begin
      r = $urandom;
      desc_tab[j][k].pad_top    = r[7:0];
      desc_tab[j][k].pad_bottom = r[15:8];
      desc_tab[j][k].pad_left   = r[23:16];
      desc_tab[j][k].pad_right  = r[31:24];
      desc_tab[j][k].src_ptr    = $urandom;
      desc_tab[j][k].dst_ptr    = $urandom;
      r = $urandom;
      desc_tab[j][k].in_inc_d2  = r[22:0];
      r = $urandom;
      desc_tab[j][k].size_d1    = r[15:0];
      desc_tab[j][k].size_d2    = r[31:16];
      desc_tab[j][k].last       = (k == n - 1);
    end
  endtask

  task automatic run_job(int j);
    int k;
    int err_before;
    @(negedge clk_i);
    err_before = mon_err;
    @(posedge clk_i);
    cur_name   <= name_tab[j];
    cur_stall  <= stall_tab[j];
    cur_unmask <= unmask_tab[j];
    cfg_i      <= cfg_tab[j];
    start_i    <= 1'b1;
    @(posedge clk_i);
    start_i    <= 1'b0;
    k = 0;
    while (k < ndesc_tab[j]) begin
      @(posedge clk_i);
      if (used - returned < int'(DESC_DEPTH)) begin
        desc_valid_i <= 1'b1;
        desc_i       <= desc_tab[j][k];
        k++;
        used++;
      end else begin
        desc_valid_i <= 1'b0;  // Out of credits
      end
    end
    @(posedge clk_i);
    desc_valid_i <= 1'b0;
    while (!done_o) @(posedge clk_i);
    if (cfg_tab[j].irq_en) begin
      @(posedge clk_i);
      irq_clear_i <= 1'b1;
      @(posedge clk_i);
      irq_clear_i <= 1'b0;
    end
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    if (mon_err == err_before) $display("job %0s: ok", name_tab[j]);
    else $display("job %0s: %0d errors", name_tab[j], mon_err - err_before);
  endtask

  initial begin
    int writes;
    int descs;
    seed_val     = $urandom(32'hbdc2);
    rst_ni       = 1'b0;
    start_i      = 1'b0;
    cfg_i        = '0;
    irq_clear_i  = 1'b0;
    desc_valid_i = 1'b0;
    desc_i       = '0;
    bus_ready_i  = 1'b0;
    dma_done_i   = '0;
    cur_name     = "reset";
    cur_stall    = 0;
    cur_unmask   = '0;
    used         = 0;
    limit        = 32'hffff_ffff;
    add_job(0, "single_word", 2'd0, 1, 1'b1, 0, 0, 4'd1);
    add_job(1, "multi_half", 2'd1, 3, 1'b0, 30, 1, 4'd2);
    add_job(2, "byte_stall", 2'd2, 4, 1'b1, 60, 2, 4'd0);
    add_job(3, "credit_burst", 2'd0, MAX_DESC, 1'b0, 20, 3, 4'd3);
    add_job(4, "unmasked_done", 2'd1, 2, 1'b1, 10, 2, 4'd4);
    writes = 0;
    descs  = 0;
    for (int j = 0; j < NJOBS; j++) begin
      writes += 16 + 12 * (ndesc_tab[j] - 1);
      descs  += ndesc_tab[j];
    end
    limit = writes * MAX_STALL + descs * 20 + NJOBS * 60 + 100;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (2) @(posedge clk_i);
    for (int j = 0; j < NJOBS; j++) run_job(j);
    $display("%0d jobs run, %0d checks failed", NJOBS, mon_err);
    if (mon_err == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  always @(posedge clk_i) begin
    if (!rst_ni) returned <= 0;
    else if (credit_o) returned <= returned + 1;
  end

  // Random ready, DMA completion after each SIZE_D1 write
  always @(posedge clk_i) begin
    logic [31:0] r;
    r = $urandom % 100;
    bus_ready_i <= rst_ni && (r >= cur_stall);
    dma_done_i  <= '0;
    if (!rst_ni) begin
      dma_wait <= 0;
    end else if (dma_wait > 0) begin
      dma_wait <= dma_wait - 1;
      if (dma_wait == 7) dma_done_i <= cur_unmask;  // Must be ignored
      if (dma_wait == 1) dma_done_i <= cfg_i.ch_mask;
    end else if (bus_req_o.valid && bus_ready_i
                 && bus_req_o.addr == cfg_i.ch_offset + 32'd60) begin
      dma_wait <= 8 + $urandom % 6;
    end
  end

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      cycle_cnt <= 0;
    end else begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt > limit) begin
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("test failed");
        $finish;
      end
    end
  end

endmodule

`default_nettype wire

// File: im2col.f
design/im2col_pkg.sv
design/im2col_desc_queue.sv
design/im2col_ctrl_fsm.sv
design/im2col_reg_counter.sv
design/im2col_reg_word.sv
design/im2col_bus_master.sv
design/im2col_spc.sv
sim/im2col_chk.sv
sim/im2col_monitor.sv
sim/im2col_tb.sv

// File: Makefile
# Verilator build for the im2col sequencer testbench

LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f im2col.f --top-module im2col_tb -o Vim2col_tb

run: compile
	./obj_dir/Vim2col_tb | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
